// File: aout_cfg.svh
/*
 * Configuration macros for the audio output path.
 * Include wherever widths, FIFO depth, PWM resolution or register
 * addresses are needed. Types built on these live in aout_pkg.
 */

`ifndef AOUT_CFG_SVH
`define AOUT_CFG_SVH

// Sample and FIFO geometry
`define AOUT_SAMPLE_W    16
`define AOUT_FIFO_AW     2
`define AOUT_FIFO_DEPTH  (1 << `AOUT_FIFO_AW)
`define AOUT_LEVEL_W     3

// Playback timing
`define AOUT_INTERVAL_W  8
`define AOUT_PWM_BITS    6

// Register map
`define AOUT_REG_ADDR_W  2
`define AOUT_ADDR_CSR    2'd0
`define AOUT_ADDR_STATUS 2'd1
`define AOUT_ADDR_FIFO   2'd2

`endif

// File: aout_pkg.sv
/*
 * Shared types for the audio output path.
 * Modules refer to these by scoped name, e.g. aout_pkg::stereo_t.
 */

`include "aout_cfg.svh"

package aout_pkg;

    // One channel sample
    typedef logic [`AOUT_SAMPLE_W-1:0] sample_t;

    // Stereo word, left in the upper half
    typedef logic [2*`AOUT_SAMPLE_W-1:0] stereo_t;

    // FIFO occupancy, 0 up to the full depth
    typedef logic [`AOUT_LEVEL_W-1:0] level_t;

    // Extra PWM periods each sample is held for
    typedef logic [`AOUT_INTERVAL_W-1:0] interval_t;

    // Register port
    typedef logic [`AOUT_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Duty code, also the width of the PWM period counter
    typedef logic [`AOUT_PWM_BITS-1:0] pwm_code_t;

    typedef enum logic {
        PWM_IDLE,
        PWM_PLAY
    } pwm_state_t;

endpackage

// File: aout_regs.sv
/*
 * Register block for the audio output path.
 * Holds CSR, assembles STATUS reads and pushes stereo words into the
 * sample FIFO, converting signed samples to offset binary on the way.
 * Also raises the FIFO low-water interrupt.
 */

`include "aout_cfg.svh"

module aout_regs (
    input  logic                clk_sys,
    input  logic                rst_n_sys,
    input  logic                reg_wen_i,
    input  aout_pkg::reg_addr_t reg_addr_i,
    input  aout_pkg::reg_data_t reg_wdata_i,
    input  logic                fifo_full_i,
    input  aout_pkg::level_t    fifo_level_i,
    input  logic                running_i,
    output aout_pkg::reg_data_t reg_rdata_o,
    output logic                push_o,
    output aout_pkg::stereo_t   push_data_o,
    output logic                enable_o,
    output aout_pkg::interval_t interval_o,
    output logic                irq_o
);

    logic                csr_enable;
    logic                csr_signed;
    aout_pkg::interval_t csr_interval;
    aout_pkg::level_t    csr_irqlevel;
    logic                csr_wen;
    logic                fifo_wen;
    aout_pkg::sample_t   sign_flip;

    assign csr_wen  = reg_wen_i && (reg_addr_i == `AOUT_ADDR_CSR);
    assign fifo_wen = reg_wen_i && (reg_addr_i == `AOUT_ADDR_FIFO);

    // ----------------------------------------
    // Control register

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            csr_enable   <= 1'b0;
            csr_signed   <= 1'b0;
            csr_interval <= '0;
            csr_irqlevel <= '0;
        end else if (csr_wen) begin
            csr_enable   <= reg_wdata_i[0];
            csr_signed   <= reg_wdata_i[1];
            csr_interval <= reg_wdata_i[15:8];
            csr_irqlevel <= reg_wdata_i[18:16];
        end
    end

    assign enable_o   = csr_enable;
    assign interval_o = csr_interval;

    // ----------------------------------------
    // Sample push

    // Flipping the MSB of each half turns two's complement into offset binary
    assign sign_flip   = {csr_signed, {(`AOUT_SAMPLE_W-1){1'b0}}};
    assign push_data_o = reg_wdata_i ^ {sign_flip, sign_flip};

    // Writes to a full FIFO are dropped here
    assign push_o = fifo_wen && !fifo_full_i;

    // Low-water interrupt
    assign irq_o = (fifo_level_i <= csr_irqlevel);

    // ----------------------------------------
    // Read mux

    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            `AOUT_ADDR_CSR: begin
                reg_rdata_o[0]     = csr_enable;
                reg_rdata_o[1]     = csr_signed;
                reg_rdata_o[15:8]  = csr_interval;
                reg_rdata_o[18:16] = csr_irqlevel;
            end
            `AOUT_ADDR_STATUS: begin
                reg_rdata_o[0]    = fifo_full_i;
                reg_rdata_o[1]    = running_i;
                reg_rdata_o[10:8] = fifo_level_i;
            end
            default: reg_rdata_o = '0;
        endcase
    end

    // A push only happens while the FIFO level leaves room for it
    a_no_push_when_full: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        push_o |-> (fifo_level_i < `AOUT_FIFO_DEPTH)
    );

endmodule

// File: sample_fifo.sv
/*
 * Four-entry synchronous sample FIFO, first word fall through.
 * The head word is valid on pop_data_o whenever empty_o is low.
 * Level is the pointer difference, so push and pop together keep it.
 */

`include "aout_cfg.svh"

module sample_fifo (
    input  logic              clk_sys,
    input  logic              rst_n_sys,
    input  logic              push_i,
    input  aout_pkg::stereo_t push_data_i,
    input  logic              pop_i,
    output aout_pkg::stereo_t pop_data_o,
    output logic              empty_o,
    output logic              full_o,
    output aout_pkg::level_t  level_o
);

    localparam int AW    = `AOUT_FIFO_AW;
    localparam int DEPTH = `AOUT_FIFO_DEPTH;

    aout_pkg::stereo_t mem [DEPTH];

    // One extra bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign level_o = wr_ptr - rd_ptr;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

    assign pop_data_o = mem[rd_ptr[AW-1:0]];

    // The player must only pop a word it can see
    a_no_pop_when_empty: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        pop_i |-> !empty_o
    );

    a_level_in_range: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        level_o <= DEPTH
    );

endmodule

// File: aout_pwm.sv
/*
 * Stereo PWM player.
 * Pops one stereo word, holds it for (interval + 1) PWM periods of
 * 2**AOUT_PWM_BITS cycles, then pops the next or drops back to idle.
 * Duty comes from the top bits of each offset-binary channel.
 */

`include "aout_cfg.svh"

module aout_pwm (
    input  logic                clk_sys,
    input  logic                rst_n_sys,
    input  logic                enable_i,
    input  aout_pkg::interval_t interval_i,
    input  aout_pkg::stereo_t   sample_i,
    input  logic                empty_i,
    output logic                pop_o,
    output logic                running_o,
    output logic                audio_l_o,
    output logic                audio_r_o
);

    aout_pkg::pwm_state_t state;
    aout_pkg::pwm_state_t state_nxt;
    aout_pkg::pwm_code_t  period_cnt;
    aout_pkg::pwm_code_t  period_nxt;
    aout_pkg::interval_t  rep_cnt;
    aout_pkg::interval_t  rep_nxt;
    aout_pkg::pwm_code_t  code_l;
    aout_pkg::pwm_code_t  code_r;
    aout_pkg::pwm_code_t  code_l_nxt;
    aout_pkg::pwm_code_t  code_r_nxt;
    aout_pkg::sample_t    smp_l;
    aout_pkg::sample_t    smp_r;
    logic                 sample_end;

    assign {smp_l, smp_r} = sample_i;

    // Last cycle of the last period for the current sample
    assign sample_end = (state == aout_pkg::PWM_PLAY) && (period_cnt == '1) && (rep_cnt == '0);

    assign pop_o = enable_i && !empty_i && ((state == aout_pkg::PWM_IDLE) || sample_end);

    assign running_o = (state == aout_pkg::PWM_PLAY);

    // ----------------------------------------
    // Next-state logic

    always_comb begin
        state_nxt  = state;
        period_nxt = period_cnt;
        rep_nxt    = rep_cnt;
        code_l_nxt = code_l;
        code_r_nxt = code_r;
        if (pop_o) begin
            state_nxt  = aout_pkg::PWM_PLAY;
            period_nxt = '0;
            rep_nxt    = interval_i;
            code_l_nxt = smp_l[`AOUT_SAMPLE_W-1 -: `AOUT_PWM_BITS];
            code_r_nxt = smp_r[`AOUT_SAMPLE_W-1 -: `AOUT_PWM_BITS];
        end else if (state == aout_pkg::PWM_PLAY) begin
            period_nxt = aout_pkg::pwm_code_t'(period_cnt + 1'b1);
            if (period_cnt == '1) begin
                rep_nxt = aout_pkg::interval_t'(rep_cnt - 1'b1);
            end
            if (sample_end) begin
                state_nxt = aout_pkg::PWM_IDLE;
            end
        end
    end

    // ----------------------------------------
    // Registers

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            state      <= aout_pkg::PWM_IDLE;
            period_cnt <= '0;
            rep_cnt    <= '0;
            audio_l_o  <= 1'b0;
            audio_r_o  <= 1'b0;
        end else begin
            state      <= state_nxt;
            period_cnt <= period_nxt;
            rep_cnt    <= rep_nxt;
            // Outputs line up with period_cnt in the same cycle
            audio_l_o  <= (state_nxt == aout_pkg::PWM_PLAY) && (period_nxt < code_l_nxt);
            audio_r_o  <= (state_nxt == aout_pkg::PWM_PLAY) && (period_nxt < code_r_nxt);
        end
    end

    always_ff @(posedge clk_sys) begin
        code_l <= code_l_nxt;
        code_r <= code_r_nxt;
    end

    // Idle is only entered as the period counter wraps, with both outputs low
    a_idle_outputs_low: assert property (
        @(posedge clk_sys) disable iff (!rst_n_sys)
        (state == aout_pkg::PWM_IDLE) |-> (period_cnt == '0) && !audio_l_o && !audio_r_o
    );

endmodule

// File: aout_top.sv
/*
 * Audio output top level.
 * Register block feeds the sample FIFO, the PWM player drains it.
 * Everything runs on clk_sys.
 */

`include "aout_cfg.svh"

module aout_top (
    input  logic                clk_sys,
    input  logic                rst_n_sys,
    input  logic                reg_wen_i,
    input  aout_pkg::reg_addr_t reg_addr_i,
    input  aout_pkg::reg_data_t reg_wdata_i,
    output aout_pkg::reg_data_t reg_rdata_o,
    output logic                irq_o,
    output logic                audio_l_o,
    output logic                audio_r_o
);

    logic                push;
    aout_pkg::stereo_t   push_data;
    logic                pop;
    aout_pkg::stereo_t   pop_data;
    logic                fifo_empty;
    logic                fifo_full;
    aout_pkg::level_t    fifo_level;
    logic                enable;
    aout_pkg::interval_t interval;
    logic                running;

    aout_regs aout_regs_u (
        .clk_sys      (clk_sys),
        .rst_n_sys    (rst_n_sys),
        .reg_wen_i    (reg_wen_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .fifo_full_i  (fifo_full),
        .fifo_level_i (fifo_level),
        .running_i    (running),
        .reg_rdata_o  (reg_rdata_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .enable_o     (enable),
        .interval_o   (interval),
        .irq_o        (irq_o)
    );

    sample_fifo sample_fifo_u (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full),
        .level_o     (fifo_level)
    );

    aout_pwm aout_pwm_u (
        .clk_sys    (clk_sys),
        .rst_n_sys  (rst_n_sys),
        .enable_i   (enable),
        .interval_i (interval),
        .sample_i   (pop_data),
        .empty_i    (fifo_empty),
        .pop_o      (pop),
        .running_o  (running),
        .audio_l_o  (audio_l_o),
        .audio_r_o  (audio_r_o)
    );

endmodule

// File: tb_aout_top.sv
/*
 * Testbench for the audio output top level.
 * Drives the register port with random CSR settings and samples, keeps a
 * model of the CSR and the FIFO contents, and checks STATUS, irq_o and
 * the PWM high-cycle totals of both channels against that model.
 */

`include "aout_cfg.svh"

module tb_aout_top;

    localparam int          PLAY_TIMEOUT = 70000;
    localparam logic [31:0] CSR_MASK     = 32'h0007_ff03;

    logic                clk_sys;
    logic                rst_n_sys;
    logic                reg_wen;
    aout_pkg::reg_addr_t reg_addr;
    aout_pkg::reg_data_t reg_wdata;
    aout_pkg::reg_data_t reg_rdata;
    logic                irq;
    logic                audio_l;
    logic                audio_r;

    logic [31:0]         rng_state;
    aout_pkg::reg_data_t csr_model;
    aout_pkg::stereo_t   exp_q[$];
    int                  pass_cnt;
    int                  fail_cnt;
    int                  idle_errs;

    aout_top aout_top_i (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .reg_wen_i   (reg_wen),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .irq_o       (irq),
        .audio_l_o   (audio_l),
        .audio_r_o   (audio_r)
    );

    initial clk_sys = 1'b0;
    always #2 clk_sys = ~clk_sys;

    // ----------------------------------------
    // Helpers

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // STATUS as the model expects it while the player is idle
    function automatic logic [31:0] status_exp();
        return {21'd0, 3'(exp_q.size()), 6'd0, 1'b0, exp_q.size() == `AOUT_FIFO_DEPTH};
    endfunction

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        assert (act === exp) pass_cnt = pass_cnt + 1;
        else begin
            fail_cnt = fail_cnt + 1;
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic write_reg(input aout_pkg::reg_addr_t addr, input aout_pkg::reg_data_t data);
        @(posedge clk_sys);
        reg_wen   <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk_sys);
        reg_wen <= 1'b0;
    endtask

    task automatic read_reg(input aout_pkg::reg_addr_t addr, output aout_pkg::reg_data_t data);
        @(posedge clk_sys);
        reg_addr <= addr;
        @(negedge clk_sys);
        data = reg_rdata;
    endtask

    task automatic write_csr(input aout_pkg::reg_data_t data);
        csr_model = data & CSR_MASK;
        write_reg(`AOUT_ADDR_CSR, data);
    endtask

    // Model keeps the offset-binary word; a push while full is lost
    task automatic push_word(input aout_pkg::stereo_t data);
        if (exp_q.size() < `AOUT_FIFO_DEPTH) begin
            exp_q.push_back(csr_model[1] ? (data ^ 32'h8000_8000) : data);
        end
        write_reg(`AOUT_ADDR_FIFO, data);
    endtask

    task automatic fill_fifo(input int n);
        repeat (n) push_word(next_rand());
    endtask

    task automatic check_idle(input int cycles);
        int start_fails;
        start_fails = fail_cnt;
        @(posedge clk_sys);
        reg_addr <= `AOUT_ADDR_STATUS;
        repeat (cycles) begin
            @(negedge clk_sys);
            check_val("audio_l_o", audio_l, 1'b0);
            check_val("audio_r_o", audio_r, 1'b0);
            check_val("status.running", reg_rdata[1], 1'b0);
        end
        idle_errs += fail_cnt - start_fails;
    endtask

    // Set enable, then count high cycles until running rises and falls again
    task automatic run_playback(input aout_pkg::reg_data_t csr_val);
        int exp_l;
        int exp_r;
        int got_l;
        int got_r;
        int cyc;
        bit seen_run;
        bit done;
        exp_l = 0;
        exp_r = 0;
        got_l = 0;
        got_r = 0;
        cyc = 0;
        seen_run = 1'b0;
        done = 1'b0;
        foreach (exp_q[i]) begin
            exp_l += (int'(csr_val[15:8]) + 1) * int'(exp_q[i][31:26]);
            exp_r += (int'(csr_val[15:8]) + 1) * int'(exp_q[i][15:10]);
        end
        write_csr(csr_val | 32'h1);
        @(posedge clk_sys);
        reg_addr <= `AOUT_ADDR_STATUS;
        while (!done && cyc < PLAY_TIMEOUT) begin
            @(negedge clk_sys);
            got_l += int'(audio_l);
            got_r += int'(audio_r);
            if (reg_rdata[1]) begin
                seen_run = 1'b1;
            end else if (seen_run) begin
                done = 1'b1;
            end
            cyc++;
        end
        if (!done) begin
            $display("Timeout: playback did not start and finish within %0d cycles",
                     PLAY_TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end
        check_val("audio_l_o high cycles", got_l, exp_l);
        check_val("audio_r_o high cycles", got_r, exp_r);
        exp_q.delete();
        check_idle(200);
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        $display("Test %0d %s: %0d errors", num, name, errs);
    endtask

    // ----------------------------------------
    // Test sequence

    initial begin
        aout_pkg::reg_data_t rd;
        aout_pkg::level_t    lvl;
        int                  mark;
        rng_state = 47;
        pass_cnt  = 0;
        fail_cnt  = 0;
        idle_errs = 0;
        csr_model = '0;
        rst_n_sys = 1'b0;
        reg_wen   = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (8) @(posedge clk_sys);
        rst_n_sys <= 1'b1;
        check_idle(200);

        mark = fail_cnt;
        read_reg(`AOUT_ADDR_STATUS, rd);
        check_val("status", rd, 32'h0);
        repeat (8) begin
            write_csr(next_rand());
            read_reg(`AOUT_ADDR_CSR, rd);
            check_val("csr", rd, csr_model);
        end
        write_csr(32'h0);
        report_test(1, "csr readback", fail_cnt - mark);

        mark = fail_cnt;
        fill_fifo(5);
        read_reg(`AOUT_ADDR_STATUS, rd);
        check_val("status", rd, status_exp());
        report_test(2, "fifo fill and overflow", fail_cnt - mark);

        mark = fail_cnt;
        run_playback({16'd0, 8'(next_rand()), 8'h00});
        report_test(3, "playback totals", fail_cnt - mark);

        mark = fail_cnt;
        write_csr({16'd0, 8'(next_rand()), 8'h02});
        fill_fifo(4);
        run_playback(csr_model);
        report_test(4, "signed conversion", fail_cnt - mark);

        mark = fail_cnt;
        // Threshold below the depth so irq_o must fall during the fill
        lvl = aout_pkg::level_t'(next_rand() % `AOUT_FIFO_DEPTH);
        write_csr({13'd0, lvl, 16'd0});
        @(negedge clk_sys);
        check_val("irq_o", irq, exp_q.size() <= lvl);
        repeat (5) begin
            push_word(next_rand());
            @(negedge clk_sys);
            check_val("irq_o", irq, exp_q.size() <= lvl);
        end
        report_test(5, "low-water interrupt", fail_cnt - mark);

        report_test(6, "idle outputs", idle_errs);

        $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
aout_pkg.sv
aout_regs.sv
sample_fifo.sv
aout_pwm.sv
aout_top.sv
tb_aout_top.sv

// File: Bender.yml
package:
  name: aout

export_include_dirs:
  - .

sources:
  - files:
      - aout_pkg.sv
      - aout_regs.sv
      - sample_fifo.sv
      - aout_pwm.sv
      - aout_top.sv
  - target: test
    files:
      - tb_aout_top.sv
